/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
TOP       ?= tb_trace_encoder
FILELIST  ?= trace_encoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "test failed"; exit 1; \
	elif ! grep -q "NO ERRORS" $(LOG); then \
		echo "test did not run to the end"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* source/trace_encoder.sv */
// trace encoder top, one retired instruction per valid cycle
// output has no ready, every packet_valid_o pulse must be taken
`timescale 1ns/10ps
`default_nettype none

module trace_encoder import trdb_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       inst_valid_i,
    input  addr_t      pc_i,
    input  inst_t      inst_data_i,
    input  logic       exception_i,
    input  logic       interrupt_i,
    input  cause_t     cause_i,
    input  priv_t      priv_lvl_i,
    input  logic       trace_enable_i,
    output logic       packet_valid_o,
    output logic [3:0] packet_type_o,
    output plen_t      packet_length_o,
    output payload_t   packet_payload_o
);

    // stage pipe outputs
    addr_t  nc_pc, tc_pc;
    inst_t  tc_inst;
    priv_t  tc_priv, lc_priv;
    cause_t lc_cause;
    logic   nc_exception, tc_qualified, tc_step;
    logic   lc_exception, lc_interrupt, lc_updiscon, lc_qualified, lc_present;
    // detector
    logic   tc_branch, tc_taken, tc_updiscon;
    // branch map
    bmap_t   bmap;
    bcount_t bcount;
    logic    bmap_full, bmap_push;
    // decision
    logic           emit, flush;
    trdb_format_e   format;
    trdb_sync_sub_e subformat;

    // only traced branches go into the map
    assign bmap_push = tc_step & tc_qualified & tc_branch;

    trdb_stage_pipe i_stage_pipe (
        .clk_i(clk_i), .rst_ni(rst_ni), .inst_valid_i(inst_valid_i),
        .pc_i(pc_i), .inst_data_i(inst_data_i), .exception_i(exception_i),
        .interrupt_i(interrupt_i), .cause_i(cause_i), .priv_lvl_i(priv_lvl_i),
        .trace_enable_i(trace_enable_i), .tc_updiscon_i(tc_updiscon),
        .nc_pc_o(nc_pc), .nc_exception_o(nc_exception), .nc_inst_o(),
        .tc_pc_o(tc_pc), .tc_inst_o(tc_inst), .tc_priv_o(tc_priv),
        .tc_qualified_o(tc_qualified), .tc_step_o(tc_step),
        .lc_exception_o(lc_exception), .lc_interrupt_o(lc_interrupt),
        .lc_cause_o(lc_cause), .lc_updiscon_o(lc_updiscon),
        .lc_qualified_o(lc_qualified), .lc_priv_o(lc_priv), .lc_present_o(lc_present)
    );

    trdb_itype_detector i_itype_detector (
        .tc_inst_i(tc_inst), .tc_pc_i(tc_pc), .nc_pc_i(nc_pc),
        .tc_branch_o(tc_branch), .tc_taken_o(tc_taken), .tc_updiscon_o(tc_updiscon)
    );

    trdb_branch_map i_branch_map (
        .clk_i(clk_i), .rst_ni(rst_ni), .push_i(bmap_push), .taken_i(tc_taken),
        .flush_i(flush), .map_o(bmap), .count_o(bcount), .full_o(bmap_full)
    );

    trdb_packet_priority i_packet_priority (
        .tc_step_i(tc_step), .tc_qualified_i(tc_qualified), .lc_qualified_i(lc_qualified),
        .lc_present_i(lc_present), .tc_priv_i(tc_priv), .lc_priv_i(lc_priv),
        .lc_exception_i(lc_exception), .lc_updiscon_i(lc_updiscon),
        .nc_exception_i(nc_exception), .count_i(bcount), .tc_branch_i(tc_branch),
        .full_i(bmap_full), .emit_o(emit), .format_o(format),
        .subformat_o(subformat), .flush_o(flush)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i(clk_i), .rst_ni(rst_ni), .emit_i(emit), .format_i(format),
        .subformat_i(subformat), .tc_pc_i(tc_pc), .tc_priv_i(tc_priv),
        .lc_cause_i(lc_cause), .lc_interrupt_i(lc_interrupt), .map_i(bmap),
        .count_i(bcount), .tc_branch_i(tc_branch), .tc_taken_i(tc_taken),
        .packet_valid_o(packet_valid_o), .packet_type_o(packet_type_o),
        .packet_length_o(packet_length_o), .packet_payload_o(packet_payload_o)
    );

endmodule

`default_nettype wire

/* source/trdb_branch_map.sv */
// branch outcome accumulator, bit n holds the n-th branch since the last flush
// flush wins over a push on the same cycle
`timescale 1ns/10ps
`default_nettype none

`include "trdb_cfg.svh"

module trdb_branch_map import trdb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    push_i,
    input  logic    taken_i,
    input  logic    flush_i,
    output bmap_t   map_o,
    output bcount_t count_o,
    output logic    full_o
);

    bmap_t   map_q;
    bcount_t count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // any push this cycle went out in the packet already
            map_q   <= '0;
            count_q <= '0;
        end else if (push_i) begin
            // new outcome lands at the current count
            map_q   <= map_q | (bmap_t'(taken_i) << count_q);
            count_q <= count_q + bcount_t'(1);
        end
    end

    // raised while the push fills the last slot
    assign full_o  = push_i & (count_q == bcount_t'(`TRDB_MAP_LEN - 1));

    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

`default_nettype wire

/* source/trdb_cfg.svh */
// widths and opcodes shared by the trace encoder
// the branch map capacity must stay below 2**TRDB_COUNT_LEN
// compressed instructions are not decoded
`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

// widths
`define TRDB_XLEN        32
`define TRDB_CAUSE_LEN   5
`define TRDB_PRIV_LEN    2
`define TRDB_INST_LEN    32
`define TRDB_MAP_LEN     31
`define TRDB_COUNT_LEN   5
`define TRDB_PAYLOAD_LEN 72
`define TRDB_LEN_LEN     4

// major opcodes
`define TRDB_OP_BRANCH   7'b1100011
`define TRDB_OP_JALR     7'b1100111

`endif

/* source/trdb_itype_detector.sv */
// classifies the tc instruction, 32-bit encodings only
// taken is resolved from the nc address, so nc must be the real successor
`timescale 1ns/10ps
`default_nettype none

`include "trdb_cfg.svh"

module trdb_itype_detector import trdb_pkg::*; (
    input  inst_t tc_inst_i,
    input  addr_t tc_pc_i,
    input  addr_t nc_pc_i,
    output logic  tc_branch_o,
    output logic  tc_taken_o,
    output logic  tc_updiscon_o
);

    logic [6:0] opcode;
    addr_t      fallthrough;

    assign opcode      = tc_inst_i[6:0];
    // next sequential address
    assign fallthrough = tc_pc_i + addr_t'(4);

    // conditional branch
    assign tc_branch_o   = (opcode == `TRDB_OP_BRANCH);
    // taken when the successor is not the fallthrough
    assign tc_taken_o    = tc_branch_o & (nc_pc_i != fallthrough);
    // jalr target cannot be inferred from the binary
    assign tc_updiscon_o = (opcode == `TRDB_OP_JALR);

endmodule

`default_nettype wire

/* source/trdb_packet_emitter.sv */
// payload packing and the output register stage
// no back-pressure, packet_valid_o is a single-cycle pulse
`timescale 1ns/10ps
`default_nettype none

module trdb_packet_emitter import trdb_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           emit_i,
    input  trdb_format_e   format_i,
    input  trdb_sync_sub_e subformat_i,
    input  addr_t          tc_pc_i,
    input  priv_t          tc_priv_i,
    input  cause_t         lc_cause_i,
    input  logic           lc_interrupt_i,
    input  bmap_t          map_i,
    input  bcount_t        count_i,
    input  logic           tc_branch_i,
    input  logic           tc_taken_i,
    output logic           packet_valid_o,
    output logic [3:0]     packet_type_o,
    output plen_t          packet_length_o,
    output payload_t       packet_payload_o
);

    bmap_t    map_full;
    bcount_t  count_full;
    payload_t payload;
    plen_t    length;

    // map and count with the tc branch folded in
    assign map_full   = tc_branch_i ? (map_i | (bmap_t'(tc_taken_i) << count_i)) : map_i;
    assign count_full = count_i + bcount_t'(tc_branch_i);

    always_comb begin
        payload = '0;
        length  = '0;
        case (format_i)
            F_ADDR_BRANCH: begin
                payload[4:0]  = count_full;
                payload[35:5] = map_full;
                payload[67:36] = tc_pc_i;
                length        = plen_t'(9);
            end
            F_ADDR_ONLY: begin
                payload[31:0] = tc_pc_i;
                length        = plen_t'(4);
            end
            F_SYNC: begin
                payload[1:0]  = tc_priv_i;
                payload[33:2] = tc_pc_i;
                // start packets leave the trap fields at zero
                if (subformat_i == SF_TRAP) begin
                    payload[38:34] = lc_cause_i;
                    payload[39]    = lc_interrupt_i;
                end
                length        = plen_t'(5);
            end
            default: begin
                payload = '0;
                length  = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_i;
        end
    end

    // packet fields only move with a new packet
    always_ff @(posedge clk_i) begin
        if (emit_i) begin
            packet_type_o    <= {format_i, subformat_i};
            packet_length_o  <= length;
            packet_payload_o <= payload;
        end
    end

endmodule

`default_nettype wire

/* source/trdb_packet_priority.sv */
// packet decision for the tc instruction, valid only while tc_step_i is high
// one packet at most per instruction, any packet flushes the branch map
`timescale 1ns/10ps
`default_nettype none

module trdb_packet_priority import trdb_pkg::*; (
    input  logic           tc_step_i,
    input  logic           tc_qualified_i,
    input  logic           lc_qualified_i,
    input  logic           lc_present_i,
    input  priv_t          tc_priv_i,
    input  priv_t          lc_priv_i,
    input  logic           lc_exception_i,
    input  logic           lc_updiscon_i,
    input  logic           nc_exception_i,
    input  bcount_t        count_i,
    input  logic           tc_branch_i,
    input  logic           full_i,
    output logic           emit_o,
    output trdb_format_e   format_o,
    output trdb_sync_sub_e subformat_o,
    output logic           flush_o
);

    logic first_qualified;
    logic privchange;
    logic has_branches;

    // lc missing or untraced means tc opens the trace
    assign first_qualified = ~lc_present_i | ~lc_qualified_i;
    assign privchange      = lc_present_i & (lc_priv_i != tc_priv_i);
    // map content once the tc branch is in
    assign has_branches    = (count_i != '0) | tc_branch_i;

    always_comb begin
        emit_o      = 1'b0;
        format_o    = F_NONE;
        subformat_o = SF_START;
        if (tc_step_i && tc_qualified_i) begin
            if (first_qualified || privchange) begin
                emit_o   = 1'b1;
                format_o = F_SYNC;
            end else if (lc_exception_i) begin
                // tc is the first handler instruction
                emit_o      = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_TRAP;
            end else if (lc_updiscon_i || nc_exception_i) begin
                // jalr target, or last instruction before a trap
                emit_o   = 1'b1;
                format_o = has_branches ? F_ADDR_BRANCH : F_ADDR_ONLY;
            end else if (full_i) begin
                emit_o   = 1'b1;
                format_o = F_ADDR_BRANCH;
            end
        end
    end

    assign flush_o = emit_o;

endmodule

`default_nettype wire

/* source/trdb_pkg.sv */
// types shared by the trace encoder blocks
// widths come from the cfg header
`default_nettype none

package trdb_pkg;

`include "trdb_cfg.svh"

    typedef logic [`TRDB_XLEN-1:0]        addr_t;
    typedef logic [`TRDB_INST_LEN-1:0]    inst_t;
    typedef logic [`TRDB_CAUSE_LEN-1:0]   cause_t;
    typedef logic [`TRDB_PRIV_LEN-1:0]    priv_t;
    typedef logic [`TRDB_MAP_LEN-1:0]     bmap_t;
    typedef logic [`TRDB_COUNT_LEN-1:0]   bcount_t;
    typedef logic [`TRDB_PAYLOAD_LEN-1:0] payload_t;
    typedef logic [`TRDB_LEN_LEN-1:0]     plen_t;

    // packet format, upper half of packet_type_o
    typedef enum logic [1:0] {
        F_NONE        = 2'd0,
        F_ADDR_BRANCH = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    // format 3 subformat, lower half of packet_type_o
    typedef enum logic [1:0] {
        SF_START = 2'd0,
        SF_TRAP  = 2'd1
    } trdb_sync_sub_e;

endpackage

`default_nettype wire

/* source/trdb_stage_pipe.sv */
// nc/tc/lc window, shifts only on inst_valid_i
// inputs are only looked at while inst_valid_i is high
`timescale 1ns/10ps
`default_nettype none

module trdb_stage_pipe import trdb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    inst_valid_i,
    input  addr_t   pc_i,
    input  inst_t   inst_data_i,
    input  logic    exception_i,
    input  logic    interrupt_i,
    input  cause_t  cause_i,
    input  priv_t   priv_lvl_i,
    input  logic    trace_enable_i,
    input  logic    tc_updiscon_i,
    output addr_t   nc_pc_o,
    output logic    nc_exception_o,
    output inst_t   nc_inst_o,
    output addr_t   tc_pc_o,
    output inst_t   tc_inst_o,
    output priv_t   tc_priv_o,
    output logic    tc_qualified_o,
    output logic    tc_step_o,
    output logic    lc_exception_o,
    output logic    lc_interrupt_o,
    output cause_t  lc_cause_o,
    output logic    lc_updiscon_o,
    output logic    lc_qualified_o,
    output priv_t   lc_priv_o,
    output logic    lc_present_o
);

    // per-stage control bits
    logic   nc_present_q, tc_present_q;
    logic   nc_qual_q, tc_qual_q;
    logic   tc_exception_q;
    // per-stage payload
    logic   nc_interrupt_q, tc_interrupt_q;
    cause_t nc_cause_q, tc_cause_q;
    priv_t  nc_priv_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_present_q   <= 1'b0;
            tc_present_q   <= 1'b0;
            lc_present_o   <= 1'b0;
            nc_qual_q      <= 1'b0;
            tc_qual_q      <= 1'b0;
            lc_qualified_o <= 1'b0;
            nc_exception_o <= 1'b0;
            tc_exception_q <= 1'b0;
            lc_exception_o <= 1'b0;
            lc_updiscon_o  <= 1'b0;
            tc_step_o      <= 1'b0;
        end else begin
            // step marks the one cycle a fresh instruction sits in tc
            tc_step_o <= inst_valid_i & nc_present_q;
            if (inst_valid_i) begin
                nc_present_q   <= 1'b1;
                tc_present_q   <= nc_present_q;
                lc_present_o   <= tc_present_q;
                nc_qual_q      <= trace_enable_i;
                tc_qual_q      <= nc_present_q & nc_qual_q;
                lc_qualified_o <= tc_present_q & tc_qual_q;
                nc_exception_o <= exception_i;
                tc_exception_q <= nc_exception_o;
                lc_exception_o <= tc_exception_q;
                // detector output is garbage on an empty tc
                lc_updiscon_o  <= tc_present_q & tc_updiscon_i;
            end
        end
    end

    // payload shift, no reset
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            nc_pc_o        <= pc_i;
            nc_inst_o      <= inst_data_i;
            nc_interrupt_q <= interrupt_i;
            nc_cause_q     <= cause_i;
            nc_priv_q      <= priv_lvl_i;
            tc_pc_o        <= nc_pc_o;
            tc_inst_o      <= nc_inst_o;
            tc_interrupt_q <= nc_interrupt_q;
            tc_cause_q     <= nc_cause_q;
            tc_priv_o      <= nc_priv_q;
            lc_interrupt_o <= tc_interrupt_q;
            lc_cause_o     <= tc_cause_q;
            lc_priv_o      <= tc_priv_o;
        end
    end

    assign tc_qualified_o = tc_qual_q;

endmodule

`default_nettype wire

/* tests/tb_trace_encoder.sv */
// drives an instruction table and checks the packets against an expected table
// the table runs twice and the second pass adds random idle gaps between instructions
`timescale 1ns/10ps
`default_nettype none

module tb_trace_encoder import trdb_pkg::*; ();

    localparam int          MAX_WAIT = 50;
    localparam inst_t       NOP  = 32'h0000_0013;
    localparam inst_t       BEQ  = 32'h0000_0063;
    localparam inst_t       JALR = 32'h0000_8067;
    // outcomes of the long branch run
    // bit 31 belongs to the branch after the full map
    localparam logic [31:0] BR_OUTCOMES = 32'hed4b_96c5;

    typedef struct packed {
        addr_t  pc;
        inst_t  word;
        logic   exc;
        logic   irq;
        cause_t cause;
        priv_t  priv;
        logic   en;
    } inst_entry_t;

    typedef struct packed {
        logic [3:0] ptype;
        plen_t      len;
        payload_t   payload;
    } pkt_entry_t;

    logic       clk_i, rst_ni, inst_valid_i;
    addr_t      pc_i;
    inst_t      inst_data_i;
    logic       exception_i, interrupt_i, trace_enable_i;
    cause_t     cause_i;
    priv_t      priv_lvl_i;
    logic       packet_valid_o;
    logic [3:0] packet_type_o;
    plen_t      packet_length_o;
    payload_t   packet_payload_o;

    inst_entry_t inst_tab[$];
    pkt_entry_t  pkt_tab[$];
    pkt_entry_t  exp_pkt;
    inst_entry_t tail;
    int          exp_idx;
    logic [31:0] rnd_state;

    trace_encoder uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic add_inst(input addr_t pc, input inst_t word, input logic exc,
                            input logic irq, input cause_t cause, input priv_t priv,
                            input logic en);
        inst_tab.push_back({pc, word, exc, irq, cause, priv, en});
    endtask

    task automatic add_pkt(input logic [3:0] ptype, input plen_t len, input payload_t payload);
        pkt_tab.push_back({ptype, len, payload});
    endtask

    task automatic build_tables();
        addr_t pc;
        addr_t b30_pc;
        // first traced instruction then a taken and a not taken branch before a jalr
        add_inst(32'h100, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'hc, 4'd5, {38'h0, 32'h100, 2'd3});
        add_inst(32'h104, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_inst(32'h108, BEQ,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_inst(32'h200, BEQ,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_inst(32'h204, JALR, 1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        // jalr target gives map 2'b01 with count 2
        add_inst(32'h300, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'h4, 4'd9, {4'h0, 32'h300, 31'h1, 5'd2});
        // jalr with nothing pending
        add_inst(32'h304, JALR, 1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_inst(32'h400, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'h8, 4'd4, {40'h0, 32'h400});
        // not taken branch pending when the exception comes
        add_inst(32'h404, BEQ,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_inst(32'h408, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'h4, 4'd9, {4'h0, 32'h408, 31'h0, 5'd1});
        add_inst(32'h40c, NOP,  1'b1, 1'b0, 5'd2, 2'd3, 1'b1);
        // handler
        add_inst(32'h800, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'hd, 4'd5, {32'h0, 1'b0, 5'd2, 32'h800, 2'd3});
        // interrupt with an empty map
        add_inst(32'h804, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'h8, 4'd4, {40'h0, 32'h804});
        add_inst(32'h808, NOP,  1'b1, 1'b1, 5'd7, 2'd3, 1'b1);
        add_inst(32'h900, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'hd, 4'd5, {32'h0, 1'b1, 5'd7, 32'h900, 2'd3});
        // drop to user mode
        add_inst(32'h904, NOP,  1'b0, 1'b0, 5'd0, 2'd0, 1'b1);
        add_pkt(4'hc, 4'd5, {38'h0, 32'h904, 2'd0});
        // 31 branches fill the map and number 32 opens a fresh one
        pc = 32'h1000;
        b30_pc = '0;
        for (int i = 0; i < 32; i++) begin
            add_inst(pc, BEQ, 1'b0, 1'b0, 5'd0, 2'd0, 1'b1);
            if (i == 30) begin
                b30_pc = pc;
            end
            // taken jumps forward by 0x40
            pc = BR_OUTCOMES[i] ? pc + 32'h40 : pc + 32'h4;
        end
        add_pkt(4'h4, 4'd9, {4'h0, b30_pc, BR_OUTCOMES[30:0], 5'd31});
        add_inst(pc, JALR, 1'b0, 1'b0, 5'd0, 2'd0, 1'b1);
        add_inst(32'h3000, NOP,  1'b0, 1'b0, 5'd0, 2'd0, 1'b1);
        add_pkt(4'h4, 4'd9, {4'h0, 32'h3000, 31'h1, 5'd1});
        // untraced jalr and trap stay silent
        add_inst(32'h3004, JALR, 1'b0, 1'b0, 5'd0, 2'd0, 1'b0);
        add_inst(32'h3100, NOP,  1'b0, 1'b0, 5'd0, 2'd0, 1'b0);
        add_inst(32'h3104, NOP,  1'b1, 1'b0, 5'd4, 2'd0, 1'b0);
        add_inst(32'h3200, NOP,  1'b0, 1'b0, 5'd0, 2'd0, 1'b0);
        // tracing back on in machine mode
        add_inst(32'h4000, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
        add_pkt(4'hc, 4'd5, {38'h0, 32'h4000, 2'd3});
        add_inst(32'h4004, NOP,  1'b0, 1'b0, 5'd0, 2'd3, 1'b1);
    endtask

    task automatic drive_inst(input inst_entry_t e);
        inst_valid_i   = 1'b1;
        pc_i           = e.pc;
        inst_data_i    = e.word;
        exception_i    = e.exc;
        interrupt_i    = e.irq;
        cause_i        = e.cause;
        priv_lvl_i     = e.priv;
        trace_enable_i = e.en;
        @(posedge clk_i);
        #2;
    endtask

    // idle cycle with junk on the ignored inputs
    task automatic drive_idle();
        rnd_state      = xorshift32(rnd_state);
        inst_valid_i   = 1'b0;
        pc_i           = rnd_state;
        exception_i    = 1'b1;
        trace_enable_i = rnd_state[0];
        @(posedge clk_i);
        #2;
    endtask

    task automatic apply_reset();
        rst_ni       = 1'b0;
        inst_valid_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_ni  = 1'b1;
        exp_idx = 0;
    endtask

    task automatic wait_for_packets();
        int cycles;
        cycles = 0;
        while (exp_idx < pkt_tab.size() && cycles < MAX_WAIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_idx < pkt_tab.size()) begin
            stop_with_failure($sformatf("timeout, only %0d of %0d packets came out",
                                        exp_idx, pkt_tab.size()));
        end
        // a few quiet cycles to catch a stray packet
        repeat (4) @(posedge clk_i);
        #2;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin
        if (rst_ni && packet_valid_o) begin
            assert (exp_idx < pkt_tab.size())
            else stop_with_failure($sformatf("FAILED %0t: extra packet of type %h",
                                             $time, packet_type_o));
            if (exp_idx < pkt_tab.size()) begin
                exp_pkt = pkt_tab[exp_idx];
                assert (packet_type_o == exp_pkt.ptype && packet_length_o == exp_pkt.len
                        && packet_payload_o == exp_pkt.payload)
                else stop_with_failure($sformatf(
                    "FAILED %0t: packet %0d is %h/%0d/%h, expected %h/%0d/%h",
                    $time, exp_idx, packet_type_o, packet_length_o, packet_payload_o,
                    exp_pkt.ptype, exp_pkt.len, exp_pkt.payload));
                exp_idx++;
            end
        end
    end

    initial begin
        rst_ni         = 1'b0;
        inst_valid_i   = 1'b0;
        pc_i           = '0;
        inst_data_i    = '0;
        exception_i    = 1'b0;
        interrupt_i    = 1'b0;
        cause_i        = '0;
        priv_lvl_i     = '0;
        trace_enable_i = 1'b0;
        rnd_state      = 32'h0bb04974;
        exp_idx        = 0;
        build_tables();
        for (int pass = 0; pass < 2; pass++) begin
            apply_reset();
            foreach (inst_tab[i]) begin
                if (pass == 1) begin
                    rnd_state = xorshift32(rnd_state);
                    repeat (rnd_state % 3) drive_idle();
                end
                drive_inst(inst_tab[i]);
            end
            // untraced filler pushes the last entry into tc
            tail      = '0;
            tail.pc   = inst_tab[inst_tab.size() - 1].pc + 32'h4;
            tail.word = NOP;
            drive_inst(tail);
            inst_valid_i = 1'b0;
            wait_for_packets();
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/trace_encoder_assert.sv */
// protocol checks on the packet output, bound into every trace_encoder
`timescale 1ns/10ps
`default_nettype none

module trace_encoder_assert import trdb_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input logic       packet_valid_i,
    input logic [3:0] packet_type_i,
    input plen_t      packet_length_i
);

    logic [1:0] fmt;

    // format sits in the upper half of the type
    assign fmt = packet_type_i[3:2];

    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !packet_valid_i)
        else $error("packet valid while in reset");

    format_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i |-> fmt != F_NONE)
        else $error("packet without a format");

    // 9 bytes for format 1, 4 for format 2, 5 for sync
    length_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i |-> (fmt == F_ADDR_BRANCH && packet_length_i == plen_t'(9))
                        || (fmt == F_ADDR_ONLY && packet_length_i == plen_t'(4))
                        || (fmt == F_SYNC && packet_length_i == plen_t'(5)))
        else $error("packet length does not fit its format");

endmodule

bind trace_encoder trace_encoder_assert i_assert (
    .clk_i(clk_i),
    .rst_ni(rst_ni),
    .packet_valid_i(packet_valid_o),
    .packet_type_i(packet_type_o),
    .packet_length_i(packet_length_o)
);

`default_nettype wire

/* trace_encoder.f */
+incdir+source
source/trdb_pkg.sv
source/trdb_stage_pipe.sv
source/trdb_itype_detector.sv
source/trdb_branch_map.sv
source/trdb_packet_priority.sv
source/trdb_packet_emitter.sv
source/trace_encoder.sv
tests/trace_encoder_assert.sv
tests/tb_trace_encoder.sv
